// File: design/mf_pkg.sv
`default_nettype none

package mf_pkg;

    localparam int PIX_W       = 8;
    localparam int MAX_DIM     = 32;
    localparam int COORD_W     = 6;
    localparam int PIX_ADDR_W  = 10;
    localparam int APB_ADDR_W  = 12;
    localparam int APB_DATA_W  = 32;

    // Region select lives in PADDR[11:10]
    localparam logic [1:0] REGION_IN  = 2'd0;
    localparam logic [1:0] REGION_REG = 2'd1;
    localparam logic [1:0] REGION_OUT = 2'd2;

    localparam logic [PIX_ADDR_W-1:0] REG_CTRL   = 10'd0;
    localparam logic [PIX_ADDR_W-1:0] REG_WIDTH  = 10'd1;
    localparam logic [PIX_ADDR_W-1:0] REG_HEIGHT = 10'd2;
    localparam logic [PIX_ADDR_W-1:0] REG_STATUS = 10'd3;

    localparam int WIN_TAPS    = 9;
    localparam int TAP_W       = 4;
    localparam int MEDIAN_TAP  = 4;
    localparam int SORT_PHASES = 9;

    typedef logic [PIX_W-1:0]      pixel_t;
    typedef logic [COORD_W-1:0]    coord_t;
    typedef logic [PIX_ADDR_W-1:0] pix_addr_t;
    typedef logic [TAP_W-1:0]      tap_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // Slot 0 is the upper-left neighbour, row by row
    typedef logic [WIN_TAPS-1:0][PIX_W-1:0] window_t;

    typedef struct packed {
        logic      sel;
        logic      enable;
        logic      write;
        apb_addr_t addr;
        apb_data_t wdata;
    } apb_req_t;

    typedef struct packed {
        logic      en;
        logic      we;
        pix_addr_t addr;
        pixel_t    wdata;
    } ram_port_t;

    typedef struct packed {
        coord_t width;
        coord_t height;
    } img_cfg_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_SORT,
        S_WRITE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/mf_pixel_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mf_pixel_ram (
    input  wire                     CLK,
    input  wire mf_pkg::ram_port_t  port_i,
    output mf_pkg::pixel_t          rdata_o
);

    // One image of the largest size
    mf_pkg::pixel_t mem [mf_pkg::MAX_DIM * mf_pkg::MAX_DIM];

    always_ff @(posedge CLK) begin
        if (port_i.en) begin
            if (port_i.we) begin
                mem[port_i.addr] <= port_i.wdata;
            end
            else begin
                rdata_o <= mem[port_i.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mf_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mf_apb_regs (
    input  wire                     CLK,
    input  wire                     RST,
    input  wire mf_pkg::apb_req_t   req_i,
    input  wire                     busy_i,
    input  wire                     done_i,
    input  wire mf_pkg::pixel_t     in_rdata_i,
    input  wire mf_pkg::pixel_t     out_rdata_i,
    output mf_pkg::apb_data_t       prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    output mf_pkg::img_cfg_t        cfg_o,
    output logic                    start_o,
    output mf_pkg::ram_port_t       host_in_o,
    output mf_pkg::ram_port_t       host_out_o
);

    logic               setup;
    logic               access;
    logic               reg_wr;
    logic               host_ok;
    logic [1:0]         region;
    mf_pkg::pix_addr_t  offset;
    logic [1:0]         pend_region_r;
    logic               pend_err_r;
    logic               done_r;
    mf_pkg::coord_t     width_r;
    mf_pkg::coord_t     height_r;
    mf_pkg::apb_data_t  reg_rdata;

    assign setup   = req_i.sel && !req_i.enable;
    assign access  = req_i.sel && req_i.enable;
    assign region  = req_i.addr[mf_pkg::APB_ADDR_W-1 -: 2];
    assign offset  = req_i.addr[mf_pkg::PIX_ADDR_W-1:0];
    assign reg_wr  = access && req_i.write && (region == mf_pkg::REGION_REG);
    assign host_ok = setup && !busy_i;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            pend_region_r <= mf_pkg::REGION_IN;
            pend_err_r    <= 1'b0;
            start_o       <= 1'b0;
            done_r        <= 1'b0;
            width_r       <= '0;
            height_r      <= '0;
        end
        else begin
            // Decide source and error at setup so the access phase stays consistent
            if (setup) begin
                pend_region_r <= region;
                pend_err_r    <= busy_i && (region == mf_pkg::REGION_IN ||
                                            region == mf_pkg::REGION_OUT);
            end
            start_o <= reg_wr && (offset == mf_pkg::REG_CTRL) && req_i.wdata[0] && !busy_i;
            if (reg_wr && !busy_i) begin
                if (offset == mf_pkg::REG_WIDTH) begin
                    width_r <= req_i.wdata[mf_pkg::COORD_W-1:0];
                end
                if (offset == mf_pkg::REG_HEIGHT) begin
                    height_r <= req_i.wdata[mf_pkg::COORD_W-1:0];
                end
            end
            if (start_o) begin
                done_r <= 1'b0;
            end
            else if (done_i) begin
                done_r <= 1'b1;
            end
        end
    end

    always_comb begin
        case (offset)
            mf_pkg::REG_WIDTH:  reg_rdata = mf_pkg::apb_data_t'(width_r);
            mf_pkg::REG_HEIGHT: reg_rdata = mf_pkg::apb_data_t'(height_r);
            mf_pkg::REG_STATUS: reg_rdata = mf_pkg::apb_data_t'({busy_i, done_r});
            default:            reg_rdata = '0;
        endcase
    end

    always_comb begin
        case (pend_region_r)
            mf_pkg::REGION_IN:  prdata_o = mf_pkg::apb_data_t'(in_rdata_i);
            mf_pkg::REGION_OUT: prdata_o = mf_pkg::apb_data_t'(out_rdata_i);
            mf_pkg::REGION_REG: prdata_o = reg_rdata;
            default:            prdata_o = '0;
        endcase
        if (pend_err_r) begin
            prdata_o = '0;
        end
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = access && pend_err_r;
    assign cfg_o     = '{width: width_r, height: height_r};

    assign host_in_o  = '{en:    host_ok && (region == mf_pkg::REGION_IN),
                          we:    req_i.write,
                          addr:  offset,
                          wdata: req_i.wdata[mf_pkg::PIX_W-1:0]};
    assign host_out_o = '{en:    host_ok && (region == mf_pkg::REGION_OUT),
                          we:    req_i.write,
                          addr:  offset,
                          wdata: req_i.wdata[mf_pkg::PIX_W-1:0]};

endmodule

`default_nettype wire

// File: design/mf_window_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mf_window_ctrl (
    input  wire                     CLK,
    input  wire                     RST,
    input  wire mf_pkg::img_cfg_t   cfg_i,
    input  wire                     start_i,
    input  wire mf_pkg::pixel_t     in_rdata_i,
    input  wire                     sort_valid_i,
    input  wire mf_pkg::pixel_t     median_i,
    output logic                    busy_o,
    output logic                    done_o,
    output mf_pkg::ram_port_t       in_port_o,
    output mf_pkg::ram_port_t       out_port_o,
    output logic                    sort_start_o,
    output mf_pkg::window_t         window_o
);

    mf_pkg::ctrl_state_t  state_r;
    mf_pkg::coord_t       row_r;
    mf_pkg::coord_t       col_r;
    mf_pkg::coord_t       last_row;
    mf_pkg::coord_t       last_col;
    mf_pkg::tap_t         tap_r;
    mf_pkg::tap_t         tap_d_r;
    mf_pkg::pix_addr_t    row_base_r;
    mf_pkg::pix_addr_t    width_ext;
    mf_pkg::pix_addr_t    nb_row_addr;
    mf_pkg::pix_addr_t    nb_addr;
    logic [1:0]           tap_row;
    logic [1:0]           tap_col;
    logic                 pad;
    logic                 pad_d_r;
    logic                 cap_valid_r;
    logic                 last_pix;
    mf_pkg::window_t      window_r;

    assign last_row  = cfg_i.height - mf_pkg::coord_t'(1);
    assign last_col  = cfg_i.width - mf_pkg::coord_t'(1);
    assign width_ext = mf_pkg::pix_addr_t'(cfg_i.width);
    assign last_pix  = (row_r == last_row) && (col_r == last_col);

    // Tap position inside the 3x3 window
    assign tap_row = 2'(tap_r / 4'd3);
    assign tap_col = 2'(tap_r % 4'd3);

    assign pad = (tap_row == 2'd0 && row_r == '0) ||
                 (tap_row == 2'd2 && row_r == last_row) ||
                 (tap_col == 2'd0 && col_r == '0) ||
                 (tap_col == 2'd2 && col_r == last_col);

    always_comb begin
        case (tap_row)
            2'd0:    nb_row_addr = row_base_r - width_ext;
            2'd2:    nb_row_addr = row_base_r + width_ext;
            default: nb_row_addr = row_base_r;
        endcase
    end

    // Wraps for padded taps, but those never reach the memory
    assign nb_addr = nb_row_addr + mf_pkg::pix_addr_t'(col_r) +
                     mf_pkg::pix_addr_t'(tap_col) - mf_pkg::pix_addr_t'(1);

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_r    <= mf_pkg::S_IDLE;
            row_r      <= '0;
            col_r      <= '0;
            tap_r      <= '0;
            row_base_r <= '0;
        end
        else begin
            case (state_r)
                mf_pkg::S_IDLE: begin
                    if (start_i) begin
                        row_r      <= '0;
                        col_r      <= '0;
                        tap_r      <= '0;
                        row_base_r <= '0;
                        state_r    <= mf_pkg::S_FETCH;
                    end
                end
                mf_pkg::S_FETCH: begin
                    if (tap_r == mf_pkg::tap_t'(mf_pkg::WIN_TAPS - 1)) begin
                        tap_r   <= '0;
                        state_r <= mf_pkg::S_SORT;
                    end
                    else begin
                        tap_r <= tap_r + mf_pkg::tap_t'(1);
                    end
                end
                mf_pkg::S_SORT: begin
                    if (sort_valid_i) begin
                        state_r <= mf_pkg::S_WRITE;
                    end
                end
                mf_pkg::S_WRITE: begin
                    if (last_pix) begin
                        state_r <= mf_pkg::S_IDLE;
                    end
                    else if (col_r == last_col) begin
                        col_r      <= '0;
                        row_r      <= row_r + mf_pkg::coord_t'(1);
                        row_base_r <= row_base_r + width_ext;
                        state_r    <= mf_pkg::S_FETCH;
                    end
                    else begin
                        col_r   <= col_r + mf_pkg::coord_t'(1);
                        state_r <= mf_pkg::S_FETCH;
                    end
                end
                default: state_r <= mf_pkg::S_IDLE;
            endcase
        end
    end

    // Read data lands one cycle after the tap was issued
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            cap_valid_r  <= 1'b0;
            tap_d_r      <= '0;
            pad_d_r      <= 1'b0;
            sort_start_o <= 1'b0;
        end
        else begin
            cap_valid_r  <= (state_r == mf_pkg::S_FETCH);
            tap_d_r      <= tap_r;
            pad_d_r      <= pad;
            sort_start_o <= cap_valid_r && (tap_d_r == mf_pkg::tap_t'(mf_pkg::WIN_TAPS - 1));
        end
    end

    always_ff @(posedge CLK) begin
        if (cap_valid_r) begin
            window_r[tap_d_r] <= pad_d_r ? '0 : in_rdata_i;
        end
    end

    assign window_o = window_r;
    assign busy_o   = (state_r != mf_pkg::S_IDLE);
    assign done_o   = (state_r == mf_pkg::S_WRITE) && last_pix;

    assign in_port_o  = '{en:    (state_r == mf_pkg::S_FETCH) && !pad,
                          we:    1'b0,
                          addr:  nb_addr,
                          wdata: '0};
    assign out_port_o = '{en:    (state_r == mf_pkg::S_WRITE),
                          we:    (state_r == mf_pkg::S_WRITE),
                          addr:  row_base_r + mf_pkg::pix_addr_t'(col_r),
                          wdata: median_i};

endmodule

`default_nettype wire

// File: design/mf_median9.sv
`timescale 1ns/1ps
`default_nettype none

module mf_median9 (
    input  wire                     CLK,
    input  wire                     RST,
    input  wire                     start_i,
    input  wire mf_pkg::window_t    window_i,
    output logic                    valid_o,
    output mf_pkg::pixel_t          median_o
);

    mf_pkg::pixel_t  work_r [mf_pkg::WIN_TAPS];
    mf_pkg::pixel_t  nxt    [mf_pkg::WIN_TAPS];
    mf_pkg::tap_t    phase_r;
    logic            running_r;

    // Even phases swap pairs (0,1)..(6,7), odd phases (1,2)..(7,8)
    always_comb begin
        nxt = work_r;
        for (int i = 0; i < mf_pkg::WIN_TAPS - 1; i++) begin
            if ((i[0] == phase_r[0]) && (work_r[i] > work_r[i+1])) begin
                nxt[i]   = work_r[i+1];
                nxt[i+1] = work_r[i];
            end
        end
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            running_r <= 1'b0;
            phase_r   <= '0;
        end
        else if (start_i) begin
            running_r <= 1'b1;
            phase_r   <= '0;
        end
        else if (running_r) begin
            if (valid_o) begin
                running_r <= 1'b0;
            end
            else begin
                phase_r <= phase_r + mf_pkg::tap_t'(1);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start_i) begin
            for (int i = 0; i < mf_pkg::WIN_TAPS; i++) begin
                work_r[i] <= window_i[i];
            end
        end
        else if (running_r) begin
            work_r <= nxt;
        end
    end

    // A sorted set is unchanged by any phase, so the median holds after valid
    assign valid_o  = running_r && (phase_r == mf_pkg::tap_t'(mf_pkg::SORT_PHASES - 1));
    assign median_o = nxt[mf_pkg::MEDIAN_TAP];

endmodule

`default_nettype wire

// File: design/median_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module median_filter_top (
    input  wire                     CLK,
    input  wire                     RST,
    input  wire                     psel_i,
    input  wire                     penable_i,
    input  wire                     pwrite_i,
    input  wire mf_pkg::apb_addr_t  paddr_i,
    input  wire mf_pkg::apb_data_t  pwdata_i,
    output mf_pkg::apb_data_t       prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o
);

    mf_pkg::apb_req_t   apb_req;
    mf_pkg::img_cfg_t   cfg;
    mf_pkg::ram_port_t  host_in;
    mf_pkg::ram_port_t  host_out;
    mf_pkg::ram_port_t  ctrl_in;
    mf_pkg::ram_port_t  ctrl_out;
    mf_pkg::ram_port_t  in_port;
    mf_pkg::ram_port_t  out_port;
    mf_pkg::pixel_t     in_rdata;
    mf_pkg::pixel_t     out_rdata;
    mf_pkg::pixel_t     median;
    mf_pkg::window_t    window;
    logic               start;
    logic               busy;
    logic               done;
    logic               sort_start;
    logic               sort_valid;

    assign apb_req = '{sel:    psel_i,
                       enable: penable_i,
                       write:  pwrite_i,
                       addr:   paddr_i,
                       wdata:  pwdata_i};

    // The controller owns both memories for the whole job
    assign in_port  = busy ? ctrl_in  : host_in;
    assign out_port = busy ? ctrl_out : host_out;

    mf_apb_regs u_regs (
        .CLK(CLK), .RST(RST), .req_i(apb_req), .busy_i(busy), .done_i(done),
        .in_rdata_i(in_rdata), .out_rdata_i(out_rdata), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o), .cfg_o(cfg), .start_o(start),
        .host_in_o(host_in), .host_out_o(host_out)
    );

    mf_window_ctrl u_ctrl (
        .CLK(CLK), .RST(RST), .cfg_i(cfg), .start_i(start), .in_rdata_i(in_rdata),
        .sort_valid_i(sort_valid), .median_i(median), .busy_o(busy), .done_o(done),
        .in_port_o(ctrl_in), .out_port_o(ctrl_out), .sort_start_o(sort_start),
        .window_o(window)
    );

    mf_median9 u_median (
        .CLK(CLK), .RST(RST), .start_i(sort_start), .window_i(window),
        .valid_o(sort_valid), .median_o(median)
    );

    mf_pixel_ram u_in_ram (.CLK(CLK), .port_i(in_port), .rdata_o(in_rdata));

    mf_pixel_ram u_out_ram (.CLK(CLK), .port_i(out_port), .rdata_o(out_rdata));

endmodule

`default_nettype wire

// File: verification/median_filter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module median_filter_tb;

    localparam logic [1:0] PAT_CONST = 2'd0;
    localparam logic [1:0] PAT_RAMP  = 2'd1;
    localparam logic [1:0] PAT_LFSR  = 2'd2;
    localparam logic [1:0] PAT_SPOT  = 2'd3;

    typedef struct packed {
        mf_pkg::coord_t width;
        mf_pkg::coord_t height;
        logic [1:0]     pattern;
        mf_pkg::pixel_t level;
        logic           intrude;
    } case_t;

    // Width, height, pattern, pixel level, APB access during the job
    case_t cases [7] = '{
        '{6'd1,  6'd1,  PAT_CONST, 8'd200, 1'b0},
        '{6'd4,  6'd3,  PAT_CONST, 8'd90,  1'b0},
        '{6'd8,  6'd6,  PAT_RAMP,  8'd0,   1'b1},
        '{6'd7,  6'd5,  PAT_LFSR,  8'd0,   1'b0},
        '{6'd5,  6'd5,  PAT_SPOT,  8'd255, 1'b0},
        '{6'd9,  6'd1,  PAT_LFSR,  8'd0,   1'b0},
        '{6'd32, 6'd32, PAT_LFSR,  8'd0,   1'b0}
    };

    logic              CLK;
    logic              RST;
    logic              psel;
    logic              penable;
    logic              pwrite;
    mf_pkg::apb_addr_t paddr;
    mf_pkg::apb_data_t pwdata;
    mf_pkg::apb_data_t prdata;
    logic              pready;
    logic              pslverr;
    logic [16:0]       lfsr_state = 17'd94396;
    mf_pkg::pixel_t    img [1024];
    int                mismatches = 0;
    int                failures = 0;

    median_filter_top uut (
        .CLK(CLK), .RST(RST), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Taps 17 and 14
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], fb};
        return fb;
    endfunction

    function automatic mf_pkg::pixel_t random_pixel();
        mf_pkg::pixel_t p;
        p = '0;
        for (int b = 0; b < 8; b++) begin
            p = {p[6:0], lfsr_step()};
        end
        return p;
    endfunction

    // Zero-padded 3x3 neighbourhood, insertion sorted
    function automatic mf_pkg::pixel_t median_ref(int x, int y, int w, int h);
        mf_pkg::pixel_t v [9];
        mf_pkg::pixel_t t;
        int n;
        int j;
        n = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                if (x + dx >= 0 && x + dx < w && y + dy >= 0 && y + dy < h) begin
                    v[n] = img[(y + dy) * w + x + dx];
                end
                else begin
                    v[n] = '0;
                end
                n++;
            end
        end
        for (int i = 1; i < 9; i++) begin
            t = v[i];
            j = i - 1;
            while (j >= 0 && v[j] > t) begin
                v[j + 1] = v[j];
                j--;
            end
            v[j + 1] = t;
        end
        return v[4];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic apb_transfer(input logic wr, input mf_pkg::apb_addr_t addr,
                                input mf_pkg::apb_data_t wdata,
                                output mf_pkg::apb_data_t rdata, output logic err);
        int waits;
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge CLK);
        penable <= 1'b1;
        waits = 0;
        @(negedge CLK);
        while (!pready && waits < 16) begin
            @(negedge CLK);
            waits++;
        end
        assert (pready) else begin
            failures++;
            $display("APB transfer to address %0h never completed", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_word(input mf_pkg::apb_addr_t addr, input mf_pkg::apb_data_t data);
        mf_pkg::apb_data_t rd;
        logic err;
        apb_transfer(1'b1, addr, data, rd, err);
        check_value("pslverr", 0, err);
    endtask

    task automatic read_word(input mf_pkg::apb_addr_t addr, output mf_pkg::apb_data_t data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        check_value("pslverr", 0, err);
    endtask

    task automatic run_case(input case_t tc);
        int w;
        int h;
        int polls;
        mf_pkg::apb_data_t rd;
        logic err;
        mf_pkg::pixel_t p;
        w = tc.width;
        h = tc.height;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                case (tc.pattern)
                    PAT_CONST: p = tc.level;
                    PAT_RAMP:  p = mf_pkg::pixel_t'(x * 7 + y * 13);
                    PAT_LFSR:  p = random_pixel();
                    default:   p = (x == w / 2 && y == h / 2) ? tc.level : 8'd0;
                endcase
                img[y * w + x] = p;
                write_word({mf_pkg::REGION_IN, mf_pkg::pix_addr_t'(y * w + x)}, 32'(p));
            end
        end
        write_word({mf_pkg::REGION_REG, mf_pkg::REG_WIDTH}, 32'(w));
        write_word({mf_pkg::REGION_REG, mf_pkg::REG_HEIGHT}, 32'(h));
        read_word({mf_pkg::REGION_REG, mf_pkg::REG_WIDTH}, rd);
        check_value("width", 32'(w), rd);
        read_word({mf_pkg::REGION_REG, mf_pkg::REG_HEIGHT}, rd);
        check_value("height", 32'(h), rd);
        write_word({mf_pkg::REGION_REG, mf_pkg::REG_CTRL}, 32'd1);
        // Busy set, done cleared by the new start
        read_word({mf_pkg::REGION_REG, mf_pkg::REG_STATUS}, rd);
        check_value("status", 32'd2, rd);
        if (tc.intrude) begin
            apb_transfer(1'b0, {mf_pkg::REGION_IN, 10'd0}, '0, rd, err);
            check_value("pslverr", 1, err);
            check_value("prdata", 0, rd);
            apb_transfer(1'b1, {mf_pkg::REGION_IN, 10'd0}, 32'hff, rd, err);
            check_value("pslverr", 1, err);
            apb_transfer(1'b0, {mf_pkg::REGION_OUT, 10'd0}, '0, rd, err);
            check_value("pslverr", 1, err);
        end
        polls = 0;
        rd = '0;
        while (!rd[0] && polls < 20000) begin
            read_word({mf_pkg::REGION_REG, mf_pkg::REG_STATUS}, rd);
            polls++;
        end
        assert (rd[0]) else begin
            failures++;
            $display("Job of %0dx%0d never reported done", w, h);
        end
        check_value("status", 32'd1, rd);
        for (int i = 0; i < w * h; i++) begin
            read_word({mf_pkg::REGION_OUT, mf_pkg::pix_addr_t'(i)}, rd);
            check_value("prdata", 32'(median_ref(i % w, i / w, w, h)), rd);
        end
    endtask

    initial begin
        mf_pkg::apb_data_t rd;
        RST     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (16) @(posedge CLK);
        RST <= 1'b1;
        read_word({mf_pkg::REGION_REG, mf_pkg::REG_STATUS}, rd);
        check_value("status", 32'd0, rd);
        for (int i = 0; i < 7; i++) begin
            run_case(cases[i]);
        end
        $display("Mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("No errors");
        end
        else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/median_filter_assert.sv
`timescale 1ns/1ps
`default_nettype none

module median_filter_assert (
    input wire CLK,
    input wire RST,
    input wire busy_i,
    input wire done_flag_i,
    input wire out_we_i,
    input wire sort_start_i,
    input wire sort_valid_i,
    input wire psel_i,
    input wire penable_i,
    input wire pslverr_i
);

    // Done is only visible once the job has left the busy state
    busy_done_excl: assert property (@(posedge CLK) disable iff (!RST)
        !(busy_i && done_flag_i))
        else $error("busy and done flag are set together");

    out_write_busy: assert property (@(posedge CLK) disable iff (!RST)
        out_we_i |-> busy_i)
        else $error("output memory written while the job is idle");

    sort_latency: assert property (@(posedge CLK) disable iff (!RST)
        sort_start_i |-> ##(mf_pkg::SORT_PHASES) sort_valid_i)
        else $error("sorter valid did not follow its start by the phase count");

    // An error belongs to the access right after a setup seen during a job
    slverr_access: assert property (@(posedge CLK) disable iff (!RST)
        pslverr_i |-> (psel_i && penable_i && $past(psel_i && !penable_i && busy_i)))
        else $error("PSLVERR raised outside an access that was set up during a job");

endmodule

bind median_filter_top median_filter_assert u_assert (
    .CLK(CLK), .RST(RST), .busy_i(busy), .done_flag_i(u_regs.done_r),
    .out_we_i(out_port.en && out_port.we), .sort_start_i(sort_start),
    .sort_valid_i(sort_valid), .psel_i(psel_i), .penable_i(penable_i),
    .pslverr_i(pslverr_o)
);

`default_nettype wire

// File: median_filter_top.f
design/mf_pkg.sv
design/mf_pixel_ram.sv
design/mf_apb_regs.sv
design/mf_window_ctrl.sv
design/mf_median9.sv
design/median_filter_top.sv
verification/median_filter_tb.sv
verification/median_filter_assert.sv

// File: run_sim.sh
#!/bin/sh
# Build the median filter testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal --top-module median_filter_tb \
    -f median_filter_top.f -o sim_median_filter > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_median_filter > sim.log 2>&1 || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || echo "Simulation passed"
